//--- logic/cce_pkg.sv
// ##########################################################
// Shared widths, opcodes and instruction layout for the
// microcoded CCE instruction core. Modules import it inside
// their bodies and use scoped names in their port lists.
// ##########################################################
`default_nettype none

package cce_pkg;

  // Fixed by the instruction format
  localparam int cce_pc_width_c       = 8;
  localparam int cce_num_gpr_c        = 8;
  localparam int cce_gpr_sel_width_c  = 3;
  localparam int cce_num_flag_c       = 4;
  localparam int cce_flag_sel_width_c = 2;
  localparam int cce_imm_width_c      = 16;

  typedef enum logic [2:0] {
    e_op_alu    = 3'd0,
    e_op_branch = 3'd1,
    e_op_move   = 3'd2,
    e_op_flag   = 3'd3
  } cce_op_e;

  // Minor opcode, its meaning is set by the major opcode
  typedef logic [2:0] cce_minor_op_e;

  localparam cce_minor_op_e e_add_op  = 3'd0;
  localparam cce_minor_op_e e_sub_op  = 3'd1;
  localparam cce_minor_op_e e_and_op  = 3'd2;
  localparam cce_minor_op_e e_or_op   = 3'd3;
  localparam cce_minor_op_e e_addi_op = 3'd4;
  localparam cce_minor_op_e e_subi_op = 3'd5;

  localparam cce_minor_op_e e_mov_op  = 3'd0;
  localparam cce_minor_op_e e_movi_op = 3'd1;
  localparam cce_minor_op_e e_movf_op = 3'd2;

  localparam cce_minor_op_e e_setf_op = 3'd0;
  localparam cce_minor_op_e e_andf_op = 3'd1;
  localparam cce_minor_op_e e_orf_op  = 3'd2;

  localparam cce_minor_op_e e_bi_op   = 3'd0;
  localparam cce_minor_op_e e_beq_op  = 3'd1;
  localparam cce_minor_op_e e_bne_op  = 3'd2;
  localparam cce_minor_op_e e_bf_op   = 3'd3;

  // Operand field, one view per major opcode
  typedef union packed {
    struct packed {
      logic [cce_gpr_sel_width_c-1:0]  dst;
      logic [cce_gpr_sel_width_c-1:0]  src_a;
      logic [cce_gpr_sel_width_c-1:0]  src_b;
      logic                            pad;
      logic [cce_imm_width_c-1:0]      imm;
    } alu;
    struct packed {
      logic [cce_gpr_sel_width_c-1:0]  dst;
      logic [cce_gpr_sel_width_c-1:0]  src;
      logic [cce_flag_sel_width_c-1:0] src_flag;
      logic [1:0]                      pad;
      logic [cce_imm_width_c-1:0]      imm;
    } mov;
    struct packed {
      logic [cce_gpr_sel_width_c-1:0]  src_a;
      logic [cce_gpr_sel_width_c-1:0]  src_b;
      logic [cce_flag_sel_width_c-1:0] src_flag;
      logic [cce_pc_width_c-1:0]       target;
      logic [9:0]                      pad;
    } branch;
    struct packed {
      logic [cce_flag_sel_width_c-1:0] dst;
      logic [cce_flag_sel_width_c-1:0] src_a;
      logic [cce_flag_sel_width_c-1:0] src_b;
      logic [cce_gpr_sel_width_c-1:0]  dst_gpr;
      logic                            val;
      logic [15:0]                     pad;
    } flag;
  } cce_operand_u;

  typedef struct packed {
    cce_op_e       op;
    cce_minor_op_e minor;
    cce_operand_u  operand;
  } cce_inst_s;

  typedef enum logic [1:0] {
    e_src_gpr  = 2'd0,
    e_src_flag = 2'd1,
    e_src_imm  = 2'd2
  } cce_src_sel_e;

  typedef enum logic [2:0] {
    e_alu_add  = 3'd0,
    e_alu_sub  = 3'd1,
    e_alu_and  = 3'd2,
    e_alu_or   = 3'd3,
    e_alu_pass = 3'd4
  } cce_alu_fn_e;

  typedef enum logic [1:0] {
    e_br_always = 2'd0,
    e_br_eq     = 2'd1,
    e_br_ne     = 2'd2,
    e_br_flag   = 2'd3
  } cce_branch_cond_e;

  typedef struct packed {
    cce_src_sel_e                    src_a_sel;
    cce_src_sel_e                    src_b_sel;
    logic [cce_gpr_sel_width_c-1:0]  src_a_gpr;
    logic [cce_gpr_sel_width_c-1:0]  src_b_gpr;
    logic [cce_flag_sel_width_c-1:0] src_a_flag;
    logic [cce_flag_sel_width_c-1:0] src_b_flag;
    logic [cce_gpr_sel_width_c-1:0]  dst_gpr;
    logic [cce_flag_sel_width_c-1:0] dst_flag;
    cce_alu_fn_e                     alu_fn;
    logic [cce_imm_width_c-1:0]      imm;
    logic                            gpr_w_v;
    logic                            flag_w_v;
    logic                            flag_val;
    logic                            branch_v;
    cce_branch_cond_e                branch_cond;
    logic [cce_pc_width_c-1:0]       target;
  } cce_decoded_s;

endpackage

`default_nettype wire

//--- logic/cce_fetch.sv
// ##########################################################
// Fetch stage: PC register, four-phase req/ack handshake to
// the instruction source, and the execute-stage instruction
// register. One instruction is in flight at a time.
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module cce_fetch (
  input  logic                               clk_i,
  input  logic                               reset_i,
  output logic                               fetch_req_o,
  output logic [cce_pkg::cce_pc_width_c-1:0] fetch_pc_o,
  input  logic                               fetch_ack_i,
  input  cce_pkg::cce_inst_s                 fetch_inst_i,
  input  logic [cce_pkg::cce_pc_width_c-1:0] next_pc_i,
  output cce_pkg::cce_inst_s                 inst_o,
  output logic [cce_pkg::cce_pc_width_c-1:0] pc_o,
  output logic                               inst_v_o
);
  import cce_pkg::*;

  typedef enum logic [1:0] {
    e_idle = 2'd0,
    e_req  = 2'd1,
    e_wait = 2'd2
  } state_e;

  state_e                    state_r;
  state_e                    state_n;
  logic [cce_pc_width_c-1:0] pc_r;
  logic [cce_pc_width_c-1:0] ex_pc_r;
  cce_inst_s                 inst_r;
  logic                      inst_v_r;
  logic                      capture;

  // Source holds ack until req falls, so req and ack high is the capture point
  assign capture = (state_r == e_req) && fetch_ack_i;

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_idle: state_n = e_req;
      e_req: begin
        if (fetch_ack_i) begin
          state_n = e_wait;
        end
      end
      e_wait: begin
        // Re-arm only after ack is gone and the held instruction retired
        if (!fetch_ack_i && !inst_v_r) begin
          state_n = e_req;
        end
      end
      default: state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r  <= e_idle;
      pc_r     <= '0;
      inst_v_r <= 1'b0;
    end else begin
      state_r  <= state_n;
      inst_v_r <= capture;
      if (inst_v_r) begin
        pc_r <= next_pc_i;
      end
    end
  end

  // Execute-stage instruction and PC
  always_ff @(posedge clk_i) begin
    if (capture) begin
      inst_r  <= fetch_inst_i;
      ex_pc_r <= pc_r;
    end
  end

  assign fetch_req_o = (state_r == e_req);
  assign fetch_pc_o  = pc_r;
  assign inst_o      = inst_r;
  assign pc_o        = ex_pc_r;
  assign inst_v_o    = inst_v_r;

endmodule

`default_nettype wire

//--- logic/cce_inst_decode.sv
// ##########################################################
// Instruction decoder. Turns the held microcode word into the
// control bundle for the register block and execute logic.
// Purely combinational, all controls zero when nothing valid.
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module cce_inst_decode (
  input  cce_pkg::cce_inst_s    inst_i,
  input  logic                  inst_v_i,
  output cce_pkg::cce_decoded_s decoded_o
);
  import cce_pkg::*;

  always_comb begin
    decoded_o = '0;

    if (inst_v_i) begin
      case (inst_i.op)
        e_op_alu: begin
          decoded_o.dst_gpr   = inst_i.operand.alu.dst;
          decoded_o.src_a_gpr = inst_i.operand.alu.src_a;
          decoded_o.src_b_gpr = inst_i.operand.alu.src_b;
          decoded_o.src_a_sel = e_src_gpr;
          decoded_o.src_b_sel = e_src_gpr;
          decoded_o.imm       = inst_i.operand.alu.imm;
          decoded_o.gpr_w_v   = 1'b1;
          case (inst_i.minor)
            e_add_op: decoded_o.alu_fn = e_alu_add;
            e_sub_op: decoded_o.alu_fn = e_alu_sub;
            e_and_op: decoded_o.alu_fn = e_alu_and;
            e_or_op:  decoded_o.alu_fn = e_alu_or;
            e_addi_op: begin
              decoded_o.alu_fn    = e_alu_add;
              decoded_o.src_b_sel = e_src_imm;
            end
            e_subi_op: begin
              decoded_o.alu_fn    = e_alu_sub;
              decoded_o.src_b_sel = e_src_imm;
            end
            default: decoded_o.gpr_w_v = 1'b0;
          endcase
        end

        e_op_branch: begin
          decoded_o.branch_v  = 1'b1;
          decoded_o.target    = inst_i.operand.branch.target;
          decoded_o.src_a_gpr = inst_i.operand.branch.src_a;
          decoded_o.src_b_gpr = inst_i.operand.branch.src_b;
          decoded_o.src_a_sel = e_src_gpr;
          decoded_o.src_b_sel = e_src_gpr;
          case (inst_i.minor)
            e_bi_op:  decoded_o.branch_cond = e_br_always;
            e_beq_op: decoded_o.branch_cond = e_br_eq;
            e_bne_op: decoded_o.branch_cond = e_br_ne;
            e_bf_op: begin
              // Flag branches test source A as a zero-extended flag
              decoded_o.branch_cond = e_br_flag;
              decoded_o.src_a_flag  = inst_i.operand.branch.src_flag;
              decoded_o.src_a_sel   = e_src_flag;
            end
            default: decoded_o.branch_v = 1'b0;
          endcase
        end

        e_op_move: begin
          decoded_o.dst_gpr = inst_i.operand.mov.dst;
          decoded_o.imm     = inst_i.operand.mov.imm;
          decoded_o.alu_fn  = e_alu_pass;
          decoded_o.gpr_w_v = 1'b1;
          case (inst_i.minor)
            e_mov_op: begin
              decoded_o.src_a_gpr = inst_i.operand.mov.src;
              decoded_o.src_a_sel = e_src_gpr;
            end
            e_movi_op: decoded_o.src_a_sel = e_src_imm;
            e_movf_op: begin
              decoded_o.src_a_flag = inst_i.operand.mov.src_flag;
              decoded_o.src_a_sel  = e_src_flag;
            end
            default: decoded_o.gpr_w_v = 1'b0;
          endcase
        end

        e_op_flag: begin
          // Both sources are flags for the logic forms
          decoded_o.src_a_flag = inst_i.operand.flag.src_a;
          decoded_o.src_b_flag = inst_i.operand.flag.src_b;
          decoded_o.src_a_sel  = e_src_flag;
          decoded_o.src_b_sel  = e_src_flag;
          decoded_o.dst_flag   = inst_i.operand.flag.dst;
          decoded_o.dst_gpr    = inst_i.operand.flag.dst_gpr;
          decoded_o.flag_val   = inst_i.operand.flag.val;
          case (inst_i.minor)
            e_setf_op: decoded_o.flag_w_v = 1'b1;
            e_andf_op: begin
              decoded_o.alu_fn  = e_alu_and;
              decoded_o.gpr_w_v = 1'b1;
            end
            e_orf_op: begin
              decoded_o.alu_fn  = e_alu_or;
              decoded_o.gpr_w_v = 1'b1;
            end
            default: decoded_o = '0;
          endcase
        end

        // Undefined major opcodes fall through with no effect
        default: decoded_o = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/cce_reg_file.sv
// ##########################################################
// Register block beside the execute logic: eight GPRs and
// four flags. Reads are combinational, writes land on the
// edge that ends the instruction-valid cycle.
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module cce_reg_file #(
  parameter int data_width_p = 16
) (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  cce_pkg::cce_decoded_s              decoded_i,
  input  logic                               inst_v_i,
  input  logic [data_width_p-1:0]            wr_data_i,
  output logic [data_width_p-1:0]            gpr_a_o,
  output logic [data_width_p-1:0]            gpr_b_o,
  output logic [cce_pkg::cce_num_flag_c-1:0] flags_o
);
  import cce_pkg::*;

  logic [data_width_p-1:0]   gpr_r [cce_num_gpr_c];
  logic [cce_num_flag_c-1:0] flag_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < cce_num_gpr_c; i++) begin
        gpr_r[i] <= '0;
      end
      flag_r <= '0;
    end else begin
      if (inst_v_i && decoded_i.gpr_w_v) begin
        gpr_r[decoded_i.dst_gpr] <= wr_data_i;
      end
      // setf writes its immediate bit straight into the flag
      if (inst_v_i && decoded_i.flag_w_v) begin
        flag_r[decoded_i.dst_flag] <= decoded_i.flag_val;
      end
    end
  end

  assign gpr_a_o = gpr_r[decoded_i.src_a_gpr];
  assign gpr_b_o = gpr_r[decoded_i.src_b_gpr];
  assign flags_o = flag_r;

endmodule

`default_nettype wire

//--- logic/cce_execute.sv
// ##########################################################
// Execute logic: operand selection, ALU, branch condition
// and next-PC choice. Combinational; the result and next PC
// are consumed by the register block and the fetch stage.
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module cce_execute #(
  parameter int data_width_p = 16
) (
  input  cce_pkg::cce_decoded_s              decoded_i,
  input  logic [cce_pkg::cce_pc_width_c-1:0] pc_i,
  input  logic [data_width_p-1:0]            gpr_a_i,
  input  logic [data_width_p-1:0]            gpr_b_i,
  input  logic [cce_pkg::cce_num_flag_c-1:0] flags_i,
  output logic [data_width_p-1:0]            result_o,
  output logic [cce_pkg::cce_pc_width_c-1:0] next_pc_o
);
  import cce_pkg::*;

  logic [data_width_p-1:0] opd_a;
  logic [data_width_p-1:0] opd_b;
  logic                    taken;

  // Flags and the immediate are zero-extended to the data width
  always_comb begin
    case (decoded_i.src_a_sel)
      e_src_flag: opd_a = data_width_p'(flags_i[decoded_i.src_a_flag]);
      e_src_imm:  opd_a = data_width_p'(decoded_i.imm);
      default:    opd_a = gpr_a_i;
    endcase
    case (decoded_i.src_b_sel)
      e_src_flag: opd_b = data_width_p'(flags_i[decoded_i.src_b_flag]);
      e_src_imm:  opd_b = data_width_p'(decoded_i.imm);
      default:    opd_b = gpr_b_i;
    endcase
  end

  // Results wrap at the data width
  always_comb begin
    case (decoded_i.alu_fn)
      e_alu_add: result_o = opd_a + opd_b;
      e_alu_sub: result_o = opd_a - opd_b;
      e_alu_and: result_o = opd_a & opd_b;
      e_alu_or:  result_o = opd_a | opd_b;
      default:   result_o = opd_a;
    endcase
  end

  always_comb begin
    case (decoded_i.branch_cond)
      e_br_eq:   taken = (opd_a == opd_b);
      e_br_ne:   taken = (opd_a != opd_b);
      e_br_flag: taken = |opd_a;
      default:   taken = 1'b1;
    endcase
  end

  // PC plus one wraps at 256
  assign next_pc_o = (decoded_i.branch_v && taken) ? decoded_i.target : pc_i + 1'b1;

endmodule

`default_nettype wire

//--- logic/cce_core.sv
// ##########################################################
// Top level of the CCE instruction core. Fetches microcode
// over a four-phase req/ack port, executes one instruction
// at a time and reports each retire on the retire port.
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module cce_core #(
  parameter int data_width_p = 16
) (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  output logic                                    fetch_req_o,
  output logic [cce_pkg::cce_pc_width_c-1:0]      fetch_pc_o,
  input  logic                                    fetch_ack_i,
  input  cce_pkg::cce_inst_s                      fetch_inst_i,
  output logic                                    retire_v_o,
  output logic [cce_pkg::cce_pc_width_c-1:0]      retire_pc_o,
  output logic                                    retire_gpr_w_o,
  output logic [cce_pkg::cce_gpr_sel_width_c-1:0] retire_gpr_o,
  output logic [data_width_p-1:0]                 retire_data_o,
  output logic [cce_pkg::cce_num_flag_c-1:0]      flags_o
);
  import cce_pkg::*;

  cce_inst_s                 inst;
  logic                      inst_v;
  logic [cce_pc_width_c-1:0] pc;
  logic [cce_pc_width_c-1:0] next_pc;
  cce_decoded_s              decoded;
  logic [data_width_p-1:0]   gpr_a;
  logic [data_width_p-1:0]   gpr_b;
  logic [data_width_p-1:0]   result;
  logic [cce_num_flag_c-1:0] flags;

  cce_fetch fetch_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .fetch_req_o (fetch_req_o),
    .fetch_pc_o  (fetch_pc_o),
    .fetch_ack_i (fetch_ack_i),
    .fetch_inst_i(fetch_inst_i),
    .next_pc_i   (next_pc),
    .inst_o      (inst),
    .pc_o        (pc),
    .inst_v_o    (inst_v)
  );

  cce_inst_decode decode_i (
    .inst_i   (inst),
    .inst_v_i (inst_v),
    .decoded_o(decoded)
  );

  cce_reg_file #(
    .data_width_p(data_width_p)
  ) reg_file_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .decoded_i(decoded),
    .inst_v_i (inst_v),
    .wr_data_i(result),
    .gpr_a_o  (gpr_a),
    .gpr_b_o  (gpr_b),
    .flags_o  (flags)
  );

  cce_execute #(
    .data_width_p(data_width_p)
  ) execute_i (
    .decoded_i(decoded),
    .pc_i     (pc),
    .gpr_a_i  (gpr_a),
    .gpr_b_i  (gpr_b),
    .flags_i  (flags),
    .result_o (result),
    .next_pc_o(next_pc)
  );

  // Retire happens in the single cycle the held instruction is valid
  assign retire_v_o     = inst_v;
  assign retire_pc_o    = pc;
  assign retire_gpr_w_o = decoded.gpr_w_v;
  assign retire_gpr_o   = decoded.dst_gpr;
  assign retire_data_o  = result;
  assign flags_o        = flags;

endmodule

`default_nettype wire

//--- dv/cce_core_tb.sv
// ##########################################################
// Testbench for the CCE instruction core. An instruction
// memory model answers fetches with a random delay, and a
// reference model of GPRs, flags and PC checks every retire
// through concurrent assertions.
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module cce_core_tb;
  import cce_pkg::*;

  localparam int data_w = 16;

  logic              clk_i;
  logic              reset_i;
  logic              fetch_req_o;
  logic [7:0]        fetch_pc_o;
  logic              fetch_ack_i;
  cce_inst_s         fetch_inst_i;
  logic              retire_v_o;
  logic [7:0]        retire_pc_o;
  logic              retire_gpr_w_o;
  logic [2:0]        retire_gpr_o;
  logic [data_w-1:0] retire_data_o;
  logic [3:0]        flags_o;

  logic [31:0]       imem [256];
  logic [data_w-1:0] ref_gpr [8];
  logic [3:0]        ref_flags;
  logic [7:0]        ref_pc;
  cce_inst_s         cur_inst;
  logic [7:0]        cur_pc;
  logic              pend;
  logic              exp_w;
  logic [2:0]        exp_gpr;
  logic [data_w-1:0] exp_data;
  logic              exp_fw;
  logic [1:0]        exp_flag;
  logic              exp_fval;
  logic [7:0]        exp_next;
  logic [31:0]       rng_state;
  int                errors;
  int                prog_pc;
  int                seg_last [5];
  string             test_name [5] = '{"fetch handshake", "alu ops", "moves", "flags", "branches"};

  cce_core #(
    .data_width_p(data_w)
  ) cce_core_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fetch_req_o   (fetch_req_o),
    .fetch_pc_o    (fetch_pc_o),
    .fetch_ack_i   (fetch_ack_i),
    .fetch_inst_i  (fetch_inst_i),
    .retire_v_o    (retire_v_o),
    .retire_pc_o   (retire_pc_o),
    .retire_gpr_w_o(retire_gpr_w_o),
    .retire_gpr_o  (retire_gpr_o),
    .retire_data_o (retire_data_o),
    .flags_o       (flags_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // Instruction encoders, field order as in the instruction format
  function automatic logic [31:0] alu_word(input logic [2:0] minor, input logic [2:0] dst,
                                           input logic [2:0] a, input logic [2:0] b,
                                           input logic [15:0] imm);
    return {3'd0, minor, dst, a, b, 1'b0, imm};
  endfunction

  function automatic logic [31:0] move_word(input logic [2:0] minor, input logic [2:0] dst,
                                            input logic [2:0] src, input logic [1:0] flag,
                                            input logic [15:0] imm);
    return {3'd2, minor, dst, src, flag, 2'b00, imm};
  endfunction

  function automatic logic [31:0] branch_word(input logic [2:0] minor, input logic [2:0] a,
                                              input logic [2:0] b, input logic [1:0] flag,
                                              input logic [7:0] target);
    return {3'd1, minor, a, b, flag, target, 10'd0};
  endfunction

  function automatic logic [31:0] flag_word(input logic [2:0] minor, input logic [1:0] dst,
                                            input logic [1:0] a, input logic [1:0] b,
                                            input logic [2:0] dst_gpr, input logic val);
    return {3'd3, minor, dst, a, b, dst_gpr, val, 16'd0};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[prog_pc] = word;
    prog_pc++;
  endtask

  // Branch to two ahead, with a filler move that a taken branch skips
  task automatic emit_branch(input logic [2:0] minor, input logic [2:0] a,
                             input logic [2:0] b, input logic [1:0] flag);
    emit(branch_word(minor, a, b, flag, 8'(prog_pc + 2)));
    emit(move_word(3'd1, 3'd0, 3'd0, 2'd0, 16'(next_random())));
  endtask

  task automatic value_mismatch(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic protocol_error(input string msg);
    $display("Handshake error at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic abort_run(input string why);
    $display("Timeout at %0t: %s", $time, why);
    $display("*** FAILED ***");
    $finish;
  endtask

  // Expected effect of the instruction in flight
  always_comb begin : expect_result
    logic [data_w-1:0] a_val;
    logic [data_w-1:0] b_val;
    logic              taken;
    exp_w    = 1'b0;
    exp_gpr  = '0;
    exp_data = '0;
    exp_fw   = 1'b0;
    exp_flag = '0;
    exp_fval = 1'b0;
    exp_next = cur_pc + 8'd1;
    taken    = 1'b0;
    a_val    = ref_gpr[cur_inst.operand.alu.src_a];
    b_val    = ref_gpr[cur_inst.operand.alu.src_b];
    case (cur_inst.op)
      e_op_alu: begin
        exp_w   = (cur_inst.minor <= 3'd5);
        exp_gpr = cur_inst.operand.alu.dst;
        case (cur_inst.minor)
          3'd0: exp_data = a_val + b_val;
          3'd1: exp_data = a_val - b_val;
          3'd2: exp_data = a_val & b_val;
          3'd3: exp_data = a_val | b_val;
          3'd4: exp_data = a_val + cur_inst.operand.alu.imm;
          3'd5: exp_data = a_val - cur_inst.operand.alu.imm;
          default: exp_data = '0;
        endcase
      end
      e_op_move: begin
        exp_w   = (cur_inst.minor <= 3'd2);
        exp_gpr = cur_inst.operand.mov.dst;
        case (cur_inst.minor)
          3'd0: exp_data = ref_gpr[cur_inst.operand.mov.src];
          3'd1: exp_data = cur_inst.operand.mov.imm;
          3'd2: exp_data = data_w'(ref_flags[cur_inst.operand.mov.src_flag]);
          default: exp_data = '0;
        endcase
      end
      e_op_flag: begin
        exp_gpr  = cur_inst.operand.flag.dst_gpr;
        exp_flag = cur_inst.operand.flag.dst;
        exp_fval = cur_inst.operand.flag.val;
        exp_fw   = (cur_inst.minor == 3'd0);
        exp_w    = (cur_inst.minor == 3'd1) || (cur_inst.minor == 3'd2);
        if (cur_inst.minor == 3'd1) begin
          exp_data = data_w'(ref_flags[cur_inst.operand.flag.src_a] &
                             ref_flags[cur_inst.operand.flag.src_b]);
        end else begin
          exp_data = data_w'(ref_flags[cur_inst.operand.flag.src_a] |
                             ref_flags[cur_inst.operand.flag.src_b]);
        end
      end
      e_op_branch: begin
        a_val = ref_gpr[cur_inst.operand.branch.src_a];
        b_val = ref_gpr[cur_inst.operand.branch.src_b];
        case (cur_inst.minor)
          3'd0: taken = 1'b1;
          3'd1: taken = (a_val == b_val);
          3'd2: taken = (a_val != b_val);
          3'd3: taken = ref_flags[cur_inst.operand.branch.src_flag];
          default: taken = 1'b0;
        endcase
        if (taken) begin
          exp_next = cur_inst.operand.branch.target;
        end
      end
      default: exp_w = 1'b0;
    endcase
  end

  // Reference state follows the handshake and retires one cycle after capture
  always @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < 8; i++) begin
        ref_gpr[i] <= '0;
      end
      ref_flags <= '0;
      ref_pc    <= '0;
      pend      <= 1'b0;
      cur_inst  <= '0;
      cur_pc    <= '0;
    end else begin
      pend <= fetch_req_o && fetch_ack_i;
      if (fetch_req_o && fetch_ack_i) begin
        cur_inst <= imem[ref_pc];
        cur_pc   <= ref_pc;
      end
      if (pend) begin
        if (exp_w) begin
          ref_gpr[exp_gpr] <= exp_data;
        end
        if (exp_fw) begin
          ref_flags[exp_flag] <= exp_fval;
        end
        ref_pc <= exp_next;
      end
    end
  end

  a_req_drop: assert property (@(posedge clk_i) disable iff (reset_i)
    fetch_req_o && fetch_ack_i |=> !fetch_req_o)
    else protocol_error("req did not fall one cycle after ack");
  a_req_rise: assert property (@(posedge clk_i) disable iff (reset_i)
    !fetch_req_o && fetch_ack_i |=> !fetch_req_o)
    else protocol_error("req rose while ack was still high");
  a_retire_timing: assert property (@(posedge clk_i) disable iff (reset_i)
    retire_v_o == pend)
    else protocol_error("retire_v_o is not a single pulse one cycle after capture");
  a_fetch_pc: assert property (@(posedge clk_i) disable iff (reset_i)
    fetch_req_o |-> fetch_pc_o == ref_pc)
    else value_mismatch($sformatf("fetch_pc_o %0d, expected %0d", fetch_pc_o, ref_pc));
  a_retire_pc: assert property (@(posedge clk_i) disable iff (reset_i)
    retire_v_o |-> retire_pc_o == cur_pc)
    else value_mismatch($sformatf("retire_pc_o %0d, expected %0d", retire_pc_o, cur_pc));
  a_retire_w: assert property (@(posedge clk_i) disable iff (reset_i)
    retire_v_o |-> retire_gpr_w_o == exp_w)
    else value_mismatch($sformatf("retire_gpr_w_o wrong at pc %0d", cur_pc));
  a_retire_data: assert property (@(posedge clk_i) disable iff (reset_i)
    retire_v_o && exp_w |-> retire_gpr_o == exp_gpr && retire_data_o == exp_data)
    else value_mismatch($sformatf("pc %0d wrote r%0d=%h, expected r%0d=%h", cur_pc,
                                  retire_gpr_o, retire_data_o, exp_gpr, exp_data));
  a_flags: assert property (@(posedge clk_i) disable iff (reset_i)
    flags_o == ref_flags)
    else value_mismatch($sformatf("flags_o %b, expected %b", flags_o, ref_flags));

  // Instruction memory, answers each request after 0 to 3 cycles
  // and lets ack linger 0 to 3 cycles after req falls
  initial begin : responder
    int idle;
    int hold;
    int delay;
    idle = 0;
    forever begin
      @(negedge clk_i);
      if (reset_i || !fetch_req_o) begin
        idle++;
        if (idle > 40) abort_run("no fetch request from the DUT");
      end else begin
        idle  = 0;
        delay = next_random() % 4;
        repeat (delay) @(negedge clk_i);
        fetch_inst_i = imem[fetch_pc_o];
        fetch_ack_i  = 1'b1;
        hold = 0;
        while (fetch_req_o) begin
          @(negedge clk_i);
          hold++;
          if (hold > 10) abort_run("req stayed high after ack");
        end
        // A slow source keeps ack up after req has gone
        delay = next_random() % 4;
        repeat (delay) @(negedge clk_i);
        fetch_ack_i = 1'b0;
      end
    end
  end

  initial begin : main
    int wait_cnt;
    int prev_err;
    int failed_tests;
    reset_i      = 1'b1;
    fetch_ack_i  = 1'b0;
    fetch_inst_i = '0;
    errors       = 0;
    failed_tests = 0;
    prog_pc      = 0;
    rng_state    = 32'hec8d_185d;
    // Undefined opcodes everywhere, operand carries the address
    for (int a = 0; a < 256; a++) begin
      imem[a] = {3'd7, 3'd0, 18'd0, 8'(a)};
    end

    for (int r = 0; r < 8; r++) begin
      emit(move_word(3'd1, 3'(r), 3'd0, 2'd0, 16'(next_random())));
    end
    seg_last[0] = prog_pc - 1;

    emit(move_word(3'd1, 3'd7, 3'd0, 2'd0, 16'hfff0));
    emit(alu_word(3'd4, 3'd7, 3'd7, 3'd0, 16'h0025));
    emit(alu_word(3'd5, 3'd6, 3'd7, 3'd0, 16'h8000));
    for (int i = 0; i < 14; i++) begin
      emit(alu_word(3'(next_random() % 6), 3'(next_random()), 3'(next_random()),
                    3'(next_random()), 16'(next_random())));
    end
    seg_last[1] = prog_pc - 1;

    emit(flag_word(3'd0, 2'd2, 2'd0, 2'd0, 3'd0, 1'b1));
    emit(move_word(3'd2, 3'd3, 3'd0, 2'd2, 16'd0));
    emit(move_word(3'd2, 3'd4, 3'd0, 2'd1, 16'd0));
    emit(move_word(3'd0, 3'd5, 3'd1, 2'd0, 16'd0));
    emit(move_word(3'd1, 3'd6, 3'd0, 2'd0, 16'(next_random())));
    emit(move_word(3'd0, 3'd0, 3'd7, 2'd0, 16'd0));
    seg_last[2] = prog_pc - 1;

    for (int i = 0; i < 6; i++) begin
      emit(flag_word(3'd0, 2'(next_random()), 2'd0, 2'd0, 3'd0, 1'(next_random())));
    end
    for (int i = 0; i < 6; i++) begin
      emit(flag_word(3'(1 + next_random() % 2), 2'd0, 2'(next_random()), 2'(next_random()),
                     3'(next_random()), 1'b0));
    end
    seg_last[3] = prog_pc - 1;

    emit_branch(3'd0, 3'd0, 3'd0, 2'd0);
    emit(move_word(3'd1, 3'd5, 3'd0, 2'd0, 16'h0001));
    emit(move_word(3'd1, 3'd6, 3'd0, 2'd0, 16'h0002));
    emit_branch(3'd1, 3'd2, 3'd2, 2'd0);
    emit_branch(3'd1, 3'd5, 3'd6, 2'd0);
    emit_branch(3'd2, 3'd5, 3'd6, 2'd0);
    emit_branch(3'd2, 3'd3, 3'd3, 2'd0);
    emit(flag_word(3'd0, 2'd1, 2'd0, 2'd0, 3'd0, 1'b1));
    emit_branch(3'd3, 3'd0, 3'd0, 2'd1);
    emit(flag_word(3'd0, 2'd1, 2'd0, 2'd0, 3'd0, 1'b0));
    emit_branch(3'd3, 3'd0, 3'd0, 2'd1);
    // Undefined minors and majors retire with no write
    emit(alu_word(3'd6, 3'd1, 3'd1, 3'd1, 16'(next_random())));
    emit(move_word(3'd3, 3'd2, 3'd0, 2'd0, 16'(next_random())));
    emit(flag_word(3'd3, 2'd3, 2'd0, 2'd0, 3'd4, 1'b1));
    emit({3'd1, 3'd5, 26'(next_random())});
    for (int op = 4; op < 8; op++) begin
      emit({3'(op), 3'(next_random()), 26'(next_random())});
    end
    seg_last[4] = prog_pc - 1;

    repeat (2) @(negedge clk_i);
    reset_i = 1'b0;

    for (int k = 0; k < 5; k++) begin
      prev_err = errors;
      wait_cnt = 0;
      while (ref_pc <= 8'(seg_last[k])) begin
        @(negedge clk_i);
        wait_cnt++;
        if (wait_cnt > 500) abort_run($sformatf("test %s did not finish", test_name[k]));
      end
      if (errors != prev_err) begin
        failed_tests++;
      end
      $display("test %0d %-16s %s, %0d errors", k + 1, test_name[k],
               (errors == prev_err) ? "ok" : "failed", errors - prev_err);
    end

    $display("summary: 5 tests, %0d passed, %0d failed, %0d errors",
             5 - failed_tests, failed_tests, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
logic/cce_pkg.sv
logic/cce_fetch.sv
logic/cce_inst_decode.sv
logic/cce_reg_file.sv
logic/cce_execute.sv
logic/cce_core.sv
dv/cce_core_tb.sv
